// ==== rtl/rv32Pkg.sv ====
// shared widths, encodings and datapath selects for the multicycle RV32I core
// bus addresses are byte addresses, the memory keeps 1024 words
package rv32Pkg;

	localparam int xlen        = 32;
	localparam int memWords    = 1024;
	localparam int memAddrBits = 10; // word index width

	// major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		rType      = 7'b0110011,
		iTypeAlu   = 7'b0010011,
		iTypeLoad  = 7'b0000011,
		sType      = 7'b0100011,
		bType      = 7'b1100011,
		jType      = 7'b1101111,
		iTypeJalr  = 7'b1100111,
		uTypeLui   = 7'b0110111,
		uTypeAuipc = 7'b0010111
	} opcode_t;

	typedef enum logic [3:0] {
		fetch, decode, executeR, executeI, jump, memAdr, memRead, memWrite,
		memWb, aluWb, branch, lui, auipc, jalrCalc, jalrLink
	} fsmState_t;

	typedef enum logic {adrPc, adrResult} adrSrc_t;
	typedef enum logic [1:0] {srcARd1, srcAOldPc, srcAZero} aluSrcA_t;
	typedef enum logic [1:0] {srcBRd2, srcBImm, srcBFour} aluSrcB_t;
	typedef enum logic {resultAluOut, resultData} resultSrc_t;
	typedef enum logic [1:0] {pcIncrement, pcJump, pcBranch, pcAluResult} pcSrc_t;

	// operation class handed to the ALU decoder
	typedef enum logic [1:0] {aluAdd, aluCompare, aluRType, aluIType} aluOp_t;

	typedef enum logic [2:0] {immI, immS, immB, immJ, immU} immSel_t;

	// funct3 codes seen by the ALU decoder
	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3SrlSra = 3'b101;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;

	// branch conditions
	localparam logic [2:0] beqF3 = 3'b000;
	localparam logic [2:0] bneF3 = 3'b001;

endpackage

// ==== rtl/controlFsm.sv ====
// moore sequencer for the multicycle core, one state per clock
// unknown opcodes park the FSM in decode until reset, strobes stay low during reset
`timescale 1ns/10ps

module controlFsm (
	input  logic                 clk,
	input  logic                 reset,
	input  rv32Pkg::opcode_t     opcode,
	input  logic [2:0]           funct3,
	input  logic                 zero,
	output logic                 irWrite,
	output logic                 pcUpdate,
	output logic                 regWrite,
	output logic                 memWrite,
	output rv32Pkg::adrSrc_t     adrSrc,
	output rv32Pkg::aluSrcA_t    aluSrcA,
	output rv32Pkg::aluSrcB_t    aluSrcB,
	output rv32Pkg::aluOp_t      aluOp,
	output rv32Pkg::resultSrc_t  resultSrc,
	output rv32Pkg::pcSrc_t      pcSrc
);
	import rv32Pkg::*;

	fsmState_t state;
	fsmState_t nextState;
	logic      branchTaken;

	always_ff @(posedge clk) begin
		if (reset)
			state <= fetch;
		else
			state <= nextState;
	end

	// next state from the current state and the decoded opcode
	always_comb begin
		case (state)
			fetch: nextState = decode;
			decode: begin
				case (opcode)
					rType:      nextState = executeR;
					iTypeAlu:   nextState = executeI;
					iTypeLoad:  nextState = memAdr;
					sType:      nextState = memAdr;
					bType:      nextState = branch;
					jType:      nextState = jump;
					iTypeJalr:  nextState = jalrCalc;
					uTypeLui:   nextState = lui;
					uTypeAuipc: nextState = auipc;
					default:    nextState = decode; // illegal opcode, hang here
				endcase
			end
			executeR, executeI, jump, lui, auipc, jalrLink: nextState = aluWb;
			memAdr: nextState = (opcode == iTypeLoad) ? memRead : rv32Pkg::memWrite;
			memRead:  nextState = memWb;
			jalrCalc: nextState = jalrLink;
			default:  nextState = fetch; // aluWb, memWb, memWrite and branch retire
		endcase
	end

	// beq takes on equal operands, bne on unequal
	always_comb begin
		case (funct3)
			beqF3:   branchTaken = zero;
			bneF3:   branchTaken = ~zero;
			default: branchTaken = 1'b0;
		endcase
	end

	always_comb begin
		irWrite   = 1'b0;
		pcUpdate  = 1'b0;
		regWrite  = 1'b0;
		memWrite  = 1'b0;
		adrSrc    = adrPc;
		aluSrcA   = srcAOldPc;
		aluSrcB   = srcBImm;
		aluOp     = aluAdd;
		resultSrc = resultAluOut;
		pcSrc     = pcIncrement;

		// the loader owns memory while reset is high
		if (!reset) begin
			case (state)
				fetch: begin
					adrSrc   = adrPc;
					irWrite  = 1'b1;
					pcUpdate = 1'b1; // pc + 4
				end
				decode: begin
					aluSrcA = srcAOldPc; // branch and jal target
					aluSrcB = srcBImm;
				end
				executeR: begin
					aluSrcA = srcARd1;
					aluSrcB = srcBRd2;
					aluOp   = aluRType;
				end
				executeI: begin
					aluSrcA = srcARd1;
					aluSrcB = srcBImm;
					aluOp   = aluIType;
				end
				jump: begin
					aluSrcA  = srcAOldPc; // link value
					aluSrcB  = srcBFour;
					pcSrc    = pcJump;
					pcUpdate = 1'b1;
				end
				memAdr, jalrCalc: begin
					aluSrcA = srcARd1;
					aluSrcB = srcBImm;
				end
				memRead: begin
					adrSrc    = adrResult;
					resultSrc = resultAluOut;
				end
				rv32Pkg::memWrite: begin
					adrSrc    = adrResult;
					resultSrc = resultAluOut;
					memWrite  = 1'b1;
				end
				memWb: begin
					resultSrc = resultData;
					regWrite  = 1'b1;
				end
				aluWb: begin
					resultSrc = resultAluOut;
					regWrite  = 1'b1;
				end
				branch: begin
					aluSrcA  = srcARd1;
					aluSrcB  = srcBRd2;
					aluOp    = aluCompare;
					pcSrc    = branchTaken ? pcBranch : pcIncrement;
					pcUpdate = 1'b1;
				end
				lui: begin
					aluSrcA = srcAZero;
					aluSrcB = srcBImm;
				end
				auipc: begin
					aluSrcA = srcAOldPc;
					aluSrcB = srcBImm;
				end
				jalrLink: begin
					// target already sits in aluOut, compute the link meanwhile
					aluSrcA  = srcAOldPc;
					aluSrcB  = srcBFour;
					pcSrc    = pcAluResult;
					pcUpdate = 1'b1;
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/aluUnit.sv ====
// ALU decoder and arithmetic unit, compares are done as a subtraction
// shifts use the low five bits of operand B
`timescale 1ns/10ps

module aluUnit (
	input  logic [rv32Pkg::xlen-1:0] srcA,
	input  logic [rv32Pkg::xlen-1:0] srcB,
	input  rv32Pkg::aluOp_t          aluOp,
	input  logic [2:0]               funct3,
	input  logic                     funct7b5,
	output logic [rv32Pkg::xlen-1:0] result,
	output logic                     zero
);
	import rv32Pkg::*;

	typedef enum logic [3:0] {
		opAdd, opSub, opAnd, opOr, opXor, opSlt, opSltu, opSll, opSrl, opSra
	} aluCtrl_t;

	aluCtrl_t   ctrl;
	logic [4:0] shamt;

	assign shamt = srcB[4:0];

	always_comb begin
		case (aluOp)
			aluAdd:     ctrl = opAdd;
			aluCompare: ctrl = opSub;
			default: begin
				// register and immediate forms share the funct3 map
				case (funct3)
					f3AddSub: ctrl = (aluOp == aluRType && funct7b5) ? opSub : opAdd;
					f3Sll:    ctrl = opSll;
					f3Slt:    ctrl = opSlt;
					f3Sltu:   ctrl = opSltu;
					f3Xor:    ctrl = opXor;
					f3SrlSra: ctrl = funct7b5 ? opSra : opSrl; // srai uses the same bit
					f3Or:     ctrl = opOr;
					f3And:    ctrl = opAnd;
				endcase
			end
		endcase
	end

	always_comb begin
		case (ctrl)
			opAdd:   result = srcA + srcB;
			opSub:   result = srcA - srcB;
			opAnd:   result = srcA & srcB;
			opOr:    result = srcA | srcB;
			opXor:   result = srcA ^ srcB;
			opSlt:   result = {{(xlen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
			opSltu:  result = {{(xlen-1){1'b0}}, srcA < srcB};
			opSll:   result = srcA << shamt;
			opSrl:   result = srcA >> shamt;
			opSra:   result = $unsigned($signed(srcA) >>> shamt);
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== rtl/registerFile.sv ====
// 32 x 32 register file, x0 reads as zero and ignores writes
`timescale 1ns/10ps

module registerFile (
	input  logic                     clk,
	input  logic [4:0]               readAddr1,
	input  logic [4:0]               readAddr2,
	input  logic [4:0]               writeAddr,
	input  logic                     writeEnable,
	input  logic [rv32Pkg::xlen-1:0] writeData,
	output logic [rv32Pkg::xlen-1:0] readData1,
	output logic [rv32Pkg::xlen-1:0] readData2
);
	import rv32Pkg::*;

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (writeEnable && writeAddr != 5'd0)
			regs[writeAddr] <= writeData;
	end

	// asynchronous reads
	assign readData1 = (readAddr1 == 5'd0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == 5'd0) ? '0 : regs[readAddr2];

endmodule

// ==== rtl/immExtend.sv ====
// immediate builder, the format follows the opcode field
`timescale 1ns/10ps

module immExtend (
	input  logic [rv32Pkg::xlen-1:0] instr,
	output logic [rv32Pkg::xlen-1:0] imm
);
	import rv32Pkg::*;

	immSel_t immSel;

	always_comb begin
		case (opcode_t'(instr[6:0]))
			sType:                immSel = immS;
			bType:                immSel = immB;
			jType:                immSel = immJ;
			uTypeLui, uTypeAuipc: immSel = immU;
			default:              immSel = immI; // alu-imm, loads, jalr
		endcase
	end

	always_comb begin
		case (immSel)
			immS:    imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			immB:    imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
			                instr[11:8], 1'b0};
			immJ:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
			                instr[30:21], 1'b0};
			immU:    imm = {instr[31:12], 12'b0}; // upper 20 bits
			default: imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

endmodule

// ==== rtl/sharedMemory.sv ====
// single-port word memory, loader owns it during reset and the core otherwise
// byte addresses, bits [1:0] ignored, wraps every 4 KB, reads are combinational
`timescale 1ns/10ps

module sharedMemory (
	input  logic                     clk,
	input  logic                     reset,
	input  logic [rv32Pkg::xlen-1:0] coreAddr,
	input  logic [rv32Pkg::xlen-1:0] coreWriteData,
	input  logic                     coreWrite,
	input  logic                     loadEn,
	input  logic [rv32Pkg::xlen-1:0] loadAddr,
	input  logic [rv32Pkg::xlen-1:0] loadData,
	output logic [rv32Pkg::xlen-1:0] readData,
	output logic [rv32Pkg::xlen-1:0] grantAddr,
	output logic [rv32Pkg::xlen-1:0] grantWriteData,
	output logic                     grantWrite
);
	import rv32Pkg::*;

	logic [xlen-1:0]        mem [memWords];
	logic [memAddrBits-1:0] wordIndex;

	// arbiter, reset selects the loader
	assign grantAddr      = reset ? loadAddr : coreAddr;
	assign grantWriteData = reset ? loadData : coreWriteData;
	assign grantWrite     = reset ? loadEn : coreWrite;

	assign wordIndex = grantAddr[memAddrBits+1:2];

	always_ff @(posedge clk) begin
		if (grantWrite)
			mem[wordIndex] <= grantWriteData;
	end

	assign readData = mem[wordIndex];

endmodule

// ==== rtl/rv32MultiCycle.sv ====
// multicycle RV32I core top with datapath registers and muxes
// program is loaded through the loader port while reset is high, execution starts at 0
`timescale 1ns/10ps

module rv32MultiCycle (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     loadEn,
	input  logic [rv32Pkg::xlen-1:0] loadAddr,
	input  logic [rv32Pkg::xlen-1:0] loadData,
	output logic [rv32Pkg::xlen-1:0] busAddr,
	output logic [rv32Pkg::xlen-1:0] busWriteData,
	output logic                     busWrite,
	output logic [rv32Pkg::xlen-1:0] busReadData
);
	import rv32Pkg::*;

	logic       irWrite;
	logic       pcUpdate;
	logic       regWrite;
	logic       memWrite;
	adrSrc_t    adrSrc;
	aluSrcA_t   aluSrcA;
	aluSrcB_t   aluSrcB;
	aluOp_t     aluOp;
	resultSrc_t resultSrc;
	pcSrc_t     pcSrc;
	opcode_t    opcode;
	logic       zero;

	logic [xlen-1:0] pc, oldPc, instr;
	logic [xlen-1:0] regA, regB, aluOut, memData;
	logic [xlen-1:0] rd1, rd2, immExt;
	logic [xlen-1:0] srcA, srcB, aluResult, result;
	logic [xlen-1:0] pcIncr, pcNext, memAddr;

	assign opcode = opcode_t'(instr[6:0]);

	always_ff @(posedge clk) begin
		if (reset)
			pc <= '0;
		else if (pcUpdate)
			pc <= pcNext;
	end

	always_ff @(posedge clk) begin
		if (irWrite) begin
			instr <= busReadData;
			oldPc <= pc;
		end
	end

	// pipeline-style holding registers, loaded every cycle
	always_ff @(posedge clk) begin
		regA    <= rd1;
		regB    <= rd2;
		aluOut  <= aluResult;
		memData <= busReadData;
	end

	always_comb begin
		case (aluSrcA)
			srcARd1:   srcA = regA;
			srcAOldPc: srcA = oldPc;
			default:   srcA = '0; // lui
		endcase
	end

	always_comb begin
		case (aluSrcB)
			srcBRd2: srcB = regB;
			srcBImm: srcB = immExt;
			default: srcB = xlen'(4);
		endcase
	end

	assign result  = (resultSrc == resultData) ? memData : aluOut;
	assign memAddr = (adrSrc == adrResult) ? result : pc;

	// fetch bumps the live pc, a not-taken branch rebuilds the same value from oldPc
	assign pcIncr = (irWrite ? pc : oldPc) + xlen'(4);

	always_comb begin
		case (pcSrc)
			pcJump, pcBranch: pcNext = aluOut;
			pcAluResult:      pcNext = {aluOut[xlen-1:1], 1'b0}; // jalr clears bit 0
			default:          pcNext = pcIncr;
		endcase
	end

	controlFsm controlFsm_i (
		.clk       (clk),
		.reset     (reset),
		.opcode    (opcode),
		.funct3    (instr[14:12]),
		.zero      (zero),
		.irWrite   (irWrite),
		.pcUpdate  (pcUpdate),
		.regWrite  (regWrite),
		.memWrite  (memWrite),
		.adrSrc    (adrSrc),
		.aluSrcA   (aluSrcA),
		.aluSrcB   (aluSrcB),
		.aluOp     (aluOp),
		.resultSrc (resultSrc),
		.pcSrc     (pcSrc)
	);

	registerFile registerFile_i (
		.clk         (clk),
		.readAddr1   (instr[19:15]),
		.readAddr2   (instr[24:20]),
		.writeAddr   (instr[11:7]),
		.writeEnable (regWrite),
		.writeData   (result),
		.readData1   (rd1),
		.readData2   (rd2)
	);

	immExtend immExtend_i (
		.instr (instr),
		.imm   (immExt)
	);

	aluUnit aluUnit_i (
		.srcA     (srcA),
		.srcB     (srcB),
		.aluOp    (aluOp),
		.funct3   (instr[14:12]),
		.funct7b5 (instr[30]),
		.result   (aluResult),
		.zero     (zero)
	);

	sharedMemory sharedMemory_i (
		.clk            (clk),
		.reset          (reset),
		.coreAddr       (memAddr),
		.coreWriteData  (regB), // rs2 for stores
		.coreWrite      (memWrite),
		.loadEn         (loadEn),
		.loadAddr       (loadAddr),
		.loadData       (loadData),
		.readData       (busReadData),
		.grantAddr      (busAddr),
		.grantWriteData (busWriteData),
		.grantWrite     (busWrite)
	);

endmodule

// ==== tests/controlFsm_props.sv ====
// sequencing and strobe checks on the control FSM, bound into controlFsm
`timescale 1ns/10ps

module controlFsmProps (
	input logic               clk,
	input logic               reset,
	input rv32Pkg::fsmState_t state,
	input logic               irWrite,
	input logic               pcUpdate,
	input logic               regWrite,
	input logic               memWrite
);
	import rv32Pkg::*;

	int assertFails = 0;

	irWriteInFetch: assert property (@(posedge clk) irWrite |-> state == fetch)
		else begin
			$error("irWrite high outside the fetch state");
			assertFails++;
		end

	// a store and a register write never share a cycle
	noDoubleWrite: assert property (@(posedge clk) !(memWrite && regWrite))
		else begin
			$error("memWrite and regWrite high together");
			assertFails++;
		end

	quietInReset: assert property (@(posedge clk)
		reset |-> !(irWrite || pcUpdate || regWrite || memWrite))
		else begin
			$error("strobe active while reset is high");
			assertFails++;
		end

	retireToFetch: assert property (@(posedge clk) disable iff (reset)
		state inside {aluWb, memWb, rv32Pkg::memWrite, branch} |=> state == fetch)
		else begin
			$error("last state of an instruction not followed by fetch");
			assertFails++;
		end

endmodule

bind controlFsm controlFsmProps fsmProps_i (
	.clk      (clk),
	.reset    (reset),
	.state    (state),
	.irWrite  (irWrite),
	.pcUpdate (pcUpdate),
	.regWrite (regWrite),
	.memWrite (memWrite)
);

// ==== tests/rv32Tb.sv ====
// table-driven testbench where each program is loaded during reset and starts at address 0
// every program ends with a store to 0x100 and then spins on a self-jump
`timescale 1ns/10ps

module rv32Tb;
	import rv32Pkg::*;

	localparam int          nRows      = 14;
	localparam int          progWords  = 8;
	localparam int          waitCycles = 150;
	localparam logic [31:0] resultAddr = 32'h100;

	logic        clk;
	logic        reset;
	logic        loadEn;
	logic [31:0] loadAddr;
	logic [31:0] loadData;
	logic [31:0] busAddr;
	logic [31:0] busWriteData;
	logic        busWrite;
	logic [31:0] busReadData;

	logic [31:0] prog [nRows][progWords];
	logic [31:0] expAddr [nRows];
	logic [31:0] expVal [nRows];
	bit          expectWrite [nRows];
	string       rowName [nRows];

	logic [31:0] lcgState   = 32'had8cc7da;
	int          errorCount = 0;
	int          passCount  = 0;
	int          failCount  = 0;

	rv32MultiCycle dut_i (
		.clk          (clk),
		.reset        (reset),
		.loadEn       (loadEn),
		.loadAddr     (loadAddr),
		.loadData     (loadData),
		.busAddr      (busAddr),
		.busWriteData (busWriteData),
		.busWrite     (busWrite),
		.busReadData  (busReadData)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// 200 cycles of 40 ns per row
	initial begin
		#(nRows * 200 * 40);
		$display("error: run timed out after %0d ns before all tests finished", nRows * 8000);
		$display("Simulation failed");
		$finish;
	end

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// instruction encoders following the RV32I base formats
	function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rType};
	endfunction

	function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], sType};
	endfunction

	function automatic logic [31:0] encB(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], bType};
	endfunction

	function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] encJ(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, jType};
	endfunction

	function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
			input logic [11:0] imm);
		return encI(imm, rs1, 3'b000, rd, iTypeAlu);
	endfunction

	function automatic logic [31:0] storeResult(input logic [4:0] rs2);
		return encS(resultAddr[11:0], rs2, 5'd0);
	endfunction

	task automatic setRow(input int r, input string name, input logic [31:0] val,
			input bit wr);
		rowName[r]     = name;
		expAddr[r]     = resultAddr;
		expVal[r]      = val;
		expectWrite[r] = wr;
	endtask

	// upper part rounded up so that the sign-extended low 12 bits add back to v
	task automatic putConst(input int r, input int k, input logic [4:0] rd,
			input logic [31:0] v);
		logic [31:0] hi;
		hi = v + 32'h800;
		prog[r][k]     = encU(hi[31:12], rd, uTypeLui);
		prog[r][k + 1] = addi(rd, rd, v[11:0]);
	endtask

	task automatic buildAddXor(input int r, input string name, input logic [31:0] a,
			input logic [31:0] b);
		logic [31:0] sum;
		putConst(r, 0, 5'd1, a);
		putConst(r, 2, 5'd2, b);
		prog[r][4] = encR(7'd0, 5'd2, 5'd1, 3'b000, 5'd3); // add x3, x1, x2
		prog[r][5] = encR(7'd0, 5'd1, 5'd3, 3'b100, 5'd3); // xor x3, x3, x1
		prog[r][6] = storeResult(5'd3);
		prog[r][7] = encJ(21'd0, 5'd0);
		sum = a + b; // wraps modulo 2^32
		setRow(r, name, sum ^ a, 1'b1);
	endtask

	// x3 ends at 2 when the branch skips the +1 and at 3 otherwise
	task automatic buildBranch(input int r, input string name, input bit isBne,
			input logic [11:0] opB);
		bit taken;
		prog[r][0] = addi(5'd1, 5'd0, 12'd3);
		prog[r][1] = addi(5'd2, 5'd0, opB);
		prog[r][2] = addi(5'd3, 5'd0, 12'd0);
		prog[r][3] = encB(13'd8, 5'd2, 5'd1, isBne ? 3'b001 : 3'b000);
		prog[r][4] = addi(5'd3, 5'd3, 12'd1);
		prog[r][5] = addi(5'd3, 5'd3, 12'd2);
		prog[r][6] = storeResult(5'd3);
		prog[r][7] = encJ(21'd0, 5'd0);
		taken = isBne ? (opB != 12'd3) : (opB == 12'd3);
		setRow(r, name, taken ? 32'd2 : 32'd3, 1'b1);
	endtask

	task automatic buildTable();
		logic [31:0] a;
		logic [31:0] b;
		for (int r = 0; r < nRows; r++)
			for (int k = 0; k < progWords; k++)
				prog[r][k] = 32'd0;
		buildAddXor(0, "add/xor fixed", 32'h7FFF_FFFF, 32'h0000_0801);
		a = nextRandom();
		b = nextRandom();
		buildAddXor(1, "add/xor random", a, b);
		prog[2][0] = addi(5'd1, 5'd0, -12'd5);
		prog[2][1] = addi(5'd2, 5'd0, 12'd7);
		prog[2][2] = encR(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd3); // sub
		prog[2][3] = encR(7'd0, 5'd2, 5'd3, 3'b010, 5'd4);       // slt x4, x3, x2
		prog[2][4] = encR(7'd0, 5'd4, 5'd3, 3'b000, 5'd3);
		prog[2][5] = storeResult(5'd3);
		prog[2][6] = encJ(21'd0, 5'd0);
		setRow(2, "sub/slt", 32'hFFFF_FFF5, 1'b1); // (-12) + (-12 < 7) gives -11
		prog[3][0] = encU(20'h80000, 5'd1, uTypeLui);
		prog[3][1] = addi(5'd1, 5'd1, 12'h010);
		prog[3][2] = addi(5'd5, 5'd0, 12'd4);
		prog[3][3] = encR(7'b0100000, 5'd5, 5'd1, 3'b101, 5'd2); // sra by 4
		prog[3][4] = encI(12'd3, 5'd2, 3'b001, 5'd3, iTypeAlu);  // slli by 3
		prog[3][5] = storeResult(5'd3);
		prog[3][6] = encJ(21'd0, 5'd0);
		setRow(3, "sra/slli", 32'hC000_0008, 1'b1); // 0x80000010 >>> 4 = 0xF8000001
		putConst(4, 0, 5'd1, 32'h1234_5678);
		prog[4][2] = encS(12'h080, 5'd1, 5'd0);
		prog[4][3] = encI(12'h080, 5'd0, 3'b010, 5'd2, iTypeLoad);
		prog[4][4] = addi(5'd2, 5'd2, 12'd1);
		prog[4][5] = storeResult(5'd2);
		prog[4][6] = encJ(21'd0, 5'd0);
		setRow(4, "sw/lw", 32'h1234_5679, 1'b1);
		buildBranch(5, "beq taken", 1'b0, 12'd3);
		buildBranch(6, "beq not taken", 1'b0, 12'd4);
		buildBranch(7, "bne taken", 1'b1, 12'd4);
		buildBranch(8, "bne not taken", 1'b1, 12'd3);
		prog[9][0] = addi(5'd1, 5'd0, 12'd1);
		prog[9][1] = encJ(21'd8, 5'd5);                    // jal x5 at 0x4 lands at 0xC
		prog[9][2] = addi(5'd1, 5'd1, 12'd100);
		prog[9][3] = encR(7'd0, 5'd1, 5'd5, 3'b000, 5'd6);
		prog[9][4] = storeResult(5'd6);
		prog[9][5] = encJ(21'd0, 5'd0);
		setRow(9, "jal link", 32'd9, 1'b1);
		prog[10][0] = addi(5'd1, 5'd0, 12'd13);
		prog[10][1] = encI(12'd0, 5'd1, 3'b000, 5'd5, iTypeJalr); // odd sum 13
		prog[10][2] = addi(5'd5, 5'd5, 12'd100);
		prog[10][3] = encU(20'd0, 5'd6, uTypeAuipc);                // x6 = landing pc
		prog[10][4] = encR(7'd0, 5'd5, 5'd6, 3'b000, 5'd6);
		prog[10][5] = storeResult(5'd6);
		prog[10][6] = encJ(21'd0, 5'd0);
		setRow(10, "jalr odd target", 32'd12 + 32'd8, 1'b1);
		prog[11][0] = addi(5'd0, 5'd0, 12'd0);
		prog[11][1] = addi(5'd0, 5'd0, 12'd0);
		prog[11][2] = encU(20'hABCDE, 5'd2, uTypeAuipc);
		prog[11][3] = storeResult(5'd2);
		prog[11][4] = encJ(21'd0, 5'd0);
		setRow(11, "auipc", 32'hABCD_E000 + 32'h8, 1'b1);
		putConst(12, 0, 5'd1, 32'hDEAD_BEEF);
		prog[12][2] = storeResult(5'd1);
		prog[12][3] = encJ(21'd0, 5'd0);
		setRow(12, "lui/addi const", 32'hDEAD_BEEF, 1'b1);
		prog[13][0] = 32'hFFFF_FFFF; // opcode 0x7f is not implemented
		prog[13][1] = storeResult(5'd0);
		prog[13][2] = encJ(21'd0, 5'd0);
		setRow(13, "illegal opcode", 32'd0, 1'b0);
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
			errorCount++;
		end
	endtask

	// the loader writes one word per cycle during the 10 reset cycles
	task automatic loadProgram(input int r);
		@(posedge clk);
		reset <= 1'b1;
		for (int i = 0; i < 10; i++) begin
			if (i < progWords) begin
				loadEn   <= 1'b1;
				loadAddr <= 32'(i * 4);
				loadData <= prog[r][i];
			end else begin
				loadEn <= 1'b0;
			end
			@(posedge clk);
		end
		reset  <= 1'b0;
		loadEn <= 1'b0;
	endtask

	task automatic runRow(input int r);
		int cycles;
		int limit;
		int errBefore;
		bit seen;
		errBefore = errorCount;
		limit     = expectWrite[r] ? waitCycles : 100;
		seen      = 1'b0;
		cycles    = 0;
		loadProgram(r);
		@(negedge clk); // first fetch reads word 0
		cycles++;
		checkValue("busAddr", busAddr, 32'h0);
		checkValue("busReadData", busReadData, prog[r][0]);
		while (!seen && cycles < limit) begin
			@(negedge clk); // outputs settled mid-cycle
			cycles++;
			if (busWrite && (!expectWrite[r] || busAddr == expAddr[r]))
				seen = 1'b1;
		end
		if (expectWrite[r] && seen) begin
			checkValue("busWriteData", busWriteData, expVal[r]);
		end else if (expectWrite[r]) begin
			$display("error: no store to 0x%08h within %0d cycles", expAddr[r], limit);
			errorCount++;
		end else if (seen) begin
			$display("error: store to 0x%08h after an illegal opcode", busAddr);
			errorCount++;
		end
		if (errorCount == errBefore) begin
			passCount++;
			$display("test %0d %s ok", r, rowName[r]);
		end else begin
			failCount++;
			$display("test %0d %s FAILED", r, rowName[r]);
		end
	endtask

	initial begin
		int assertFails;
		reset    = 1'b1;
		loadEn   = 1'b0;
		loadAddr = 32'd0;
		loadData = 32'd0;
		buildTable();
		for (int r = 0; r < nRows; r++)
			runRow(r);
		assertFails = dut_i.controlFsm_i.fsmProps_i.assertFails;
		$display("%0d tests, %0d passed, %0d failed, %0d assertion failures",
			nRows, passCount, failCount, assertFails);
		if (failCount == 0 && assertFails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== verilog.f ====
rtl/rv32Pkg.sv
rtl/controlFsm.sv
rtl/aluUnit.sv
rtl/registerFile.sv
rtl/immExtend.sv
rtl/sharedMemory.sv
rtl/rv32MultiCycle.sv
tests/controlFsm_props.sv
tests/rv32Tb.sv
